// ==== logic/smac_config.svh ====
// packed mac configuration
`ifndef SMAC_CONFIG_SVH
`define SMAC_CONFIG_SVH

//////////////////////////////////////////////////
// datapath
//////////////////////////////////////////////////

// data, weight and packed result word
`define SMAC_DATA_W 64

//////////////////////////////////////////////////
// sequencing
//////////////////////////////////////////////////

// block length field, up to 255 beats
`define SMAC_LEN_W 8

// accepted beat to updated accumulator, in cycles
`define SMAC_DRAIN 2

`endif

// ==== logic/smac_data_pkg.sv ====
// packed mac data types
package smac_data_pkg;

  //////////////////////////////////////////////////
  // lane precision
  //////////////////////////////////////////////////

  // selects how the 64-bit words are cut into lanes
  typedef enum logic [1:0] {
    PREC_INT8  = 2'd0,  // eight 8-bit lanes
    PREC_INT16 = 2'd1,  // four 16-bit lanes
    PREC_INT32 = 2'd2   // two 32-bit lanes
  } precision_e;

  //////////////////////////////////////////////////
  // lane payloads
  //////////////////////////////////////////////////

  // each lane wraps modulo its own width
  typedef logic [7:0]  byte_t;  // int8 operand and accumulator
  typedef logic [15:0] half_t;  // int16 operand and accumulator
  typedef logic [31:0] word_t;  // int32 operand and accumulator

endpackage

// ==== logic/smac_ctrl_pkg.sv ====
// packed mac control types
package smac_ctrl_pkg;

  //////////////////////////////////////////////////
  // sequencer states
  //////////////////////////////////////////////////

  // shared by the controller and the beat counter
  typedef enum logic [1:0] {
    ST_IDLE  = 2'd0,  // waiting for start
    ST_RUN   = 2'd1,  // accepting beats
    ST_DRAIN = 2'd2,  // letting the lane pipeline settle
    ST_DONE  = 2'd3   // result held, start allowed again
  } ctrl_state_e;

endpackage

// ==== logic/mac_lane.sv ====
// multiply-accumulate lane
`timescale 1ns/1ps

module mac_lane #(
  parameter type lane_t = logic [7:0]  // lane payload, sets the lane width
) (
  input  logic  clk,
  input  logic  rst_i,
  input  logic  clear_i,  // zero the lane at block start
  input  logic  en_i,     // beat for this lane group
  input  lane_t a_i,      // data operand
  input  lane_t b_i,      // weight operand
  output lane_t acc_o     // running sum, modulo lane width
);

  lane_t a_q;    // registered data
  lane_t b_q;    // registered weight
  lane_t prod;   // truncated product
  lane_t acc_q;  // accumulator
  logic  en_q;   // enable delayed to the add stage

  //////////////////////////////////////////////////
  // stage 1, operand capture
  //////////////////////////////////////////////////
  always_ff @(posedge clk) begin
    if (clear_i) begin
      a_q <= '0;
      b_q <= '0;
    end else if (en_i) begin
      a_q <= a_i;  // hold until the next beat
      b_q <= b_i;
    end
  end

  assign prod = a_q * b_q;  // upper half dropped by lane width

  //////////////////////////////////////////////////
  // stage 2, accumulate
  //////////////////////////////////////////////////
  always_ff @(posedge clk) begin
    if (rst_i || clear_i) begin
      en_q  <= 1'b0;
      acc_q <= '0;
    end else begin
      en_q <= en_i;  // a new beat may enter while this one adds
      if (en_q) begin
        acc_q <= acc_q + prod;  // wraps modulo 2^width
      end
    end
  end

  assign acc_o = acc_q;

endmodule

// ==== logic/packed_mac.sv ====
// precision-scalable packed mac
`timescale 1ns/1ps
`include "smac_config.svh"

module packed_mac (
  input  logic                      clk,
  input  logic                      rst_i,
  input  logic                      clear_i,      // clear all lane groups
  input  logic                      beat_i,       // accepted beat
  input  smac_data_pkg::precision_e precision_i,  // active lane group
  input  logic [`SMAC_DATA_W-1:0]   data_i,
  input  logic [`SMAC_DATA_W-1:0]   weight_i,
  output logic [`SMAC_DATA_W-1:0]   result_o      // packed accumulators
);

  localparam int W8  = $bits(smac_data_pkg::byte_t);
  localparam int W16 = $bits(smac_data_pkg::half_t);
  localparam int W32 = $bits(smac_data_pkg::word_t);
  localparam int N8  = `SMAC_DATA_W / W8;   // byte lanes
  localparam int N16 = `SMAC_DATA_W / W16;  // half-word lanes
  localparam int N32 = `SMAC_DATA_W / W32;  // word lanes

  logic                    en8;    // int8 group enable
  logic                    en16;   // int16 group enable
  logic                    en32;   // int32 group enable
  logic [`SMAC_DATA_W-1:0] res8;   // packed int8 sums
  logic [`SMAC_DATA_W-1:0] res16;  // packed int16 sums
  logic [`SMAC_DATA_W-1:0] res32;  // packed int32 sums

  //////////////////////////////////////////////////
  // enable network
  //////////////////////////////////////////////////
  // only the chosen group sees the beat, the others stay frozen
  assign en8  = beat_i && (precision_i == smac_data_pkg::PREC_INT8);
  assign en16 = beat_i && (precision_i == smac_data_pkg::PREC_INT16);
  assign en32 = beat_i && (precision_i == smac_data_pkg::PREC_INT32);

  //////////////////////////////////////////////////
  // lane array
  //////////////////////////////////////////////////
  for (genvar i = 0; i < N8; i++) begin : g_int8
    mac_lane #(
      .lane_t (smac_data_pkg::byte_t)
    ) u_lane (
      .clk     (clk),
      .rst_i   (rst_i),
      .clear_i (clear_i),
      .en_i    (en8),
      .a_i     (data_i[i*W8 +: W8]),    // byte i of data
      .b_i     (weight_i[i*W8 +: W8]),  // byte i of weight
      .acc_o   (res8[i*W8 +: W8])
    );
  end

  for (genvar i = 0; i < N16; i++) begin : g_int16
    mac_lane #(
      .lane_t (smac_data_pkg::half_t)
    ) u_lane (
      .clk     (clk),
      .rst_i   (rst_i),
      .clear_i (clear_i),
      .en_i    (en16),
      .a_i     (data_i[i*W16 +: W16]),
      .b_i     (weight_i[i*W16 +: W16]),
      .acc_o   (res16[i*W16 +: W16])
    );
  end

  for (genvar i = 0; i < N32; i++) begin : g_int32
    mac_lane #(
      .lane_t (smac_data_pkg::word_t)
    ) u_lane (
      .clk     (clk),
      .rst_i   (rst_i),
      .clear_i (clear_i),
      .en_i    (en32),
      .a_i     (data_i[i*W32 +: W32]),
      .b_i     (weight_i[i*W32 +: W32]),
      .acc_o   (res32[i*W32 +: W32])
    );
  end

  //////////////////////////////////////////////////
  // result select
  //////////////////////////////////////////////////
  always_comb begin
    case (precision_i)
      smac_data_pkg::PREC_INT8:  result_o = res8;
      smac_data_pkg::PREC_INT16: result_o = res16;
      smac_data_pkg::PREC_INT32: result_o = res32;
      default:                   result_o = '0;  // unused code
    endcase
  end

endmodule

// ==== logic/beat_counter.sv ====
// beat and drain counter
`timescale 1ns/1ps
`include "smac_config.svh"

module beat_counter (
  input  logic                       clk,
  input  logic                       rst_i,
  input  logic                       load_i,     // accepted start
  input  logic                       beat_i,     // accepted beat
  input  logic [`SMAC_LEN_W-1:0]     len_i,      // block length
  input  smac_ctrl_pkg::ctrl_state_e state_i,    // sequencer state
  output logic                       last_o,     // this beat is the last
  output logic                       drained_o   // pipeline has settled
);

  localparam int LEN_W = `SMAC_LEN_W;
  localparam logic [LEN_W-1:0] DRAIN_CNT = LEN_W'(`SMAC_DRAIN);

  logic [LEN_W-1:0] cnt_q;  // remaining beats, then remaining drain cycles
  logic             run;    // counting beats
  logic             drain;  // counting drain cycles

  assign run   = (state_i == smac_ctrl_pkg::ST_RUN);
  assign drain = (state_i == smac_ctrl_pkg::ST_DRAIN);

  // one beat left and it is being taken now
  assign last_o    = beat_i && (cnt_q == LEN_W'(1));
  assign drained_o = drain && (cnt_q == '0);

  //////////////////////////////////////////////////
  // shared down-counter
  //////////////////////////////////////////////////
  always_ff @(posedge clk) begin
    if (rst_i) begin
      cnt_q <= '0;
    end else if (load_i) begin
      cnt_q <= len_i;  // beats of the new block
    end else if (run && beat_i) begin
      if (last_o) begin
        cnt_q <= DRAIN_CNT;  // same counter now times the drain
      end else begin
        cnt_q <= cnt_q - LEN_W'(1);
      end
    end else if (drain && (cnt_q != '0)) begin
      cnt_q <= cnt_q - LEN_W'(1);  // stops at zero
    end
  end

endmodule

// ==== logic/mac_ctrl.sv ====
// packed mac sequencer
`timescale 1ns/1ps

module mac_ctrl (
  input  logic                       clk,
  input  logic                       rst_i,
  input  logic                       start_i,      // start pulse
  input  logic                       valid_i,      // beat strobe
  input  logic                       last_i,       // last beat being taken
  input  logic                       drained_i,    // drain finished
  input  smac_data_pkg::precision_e  precision_i,  // precision at start
  input  logic                       len_zero_i,   // empty block
  output smac_ctrl_pkg::ctrl_state_e state_o,
  output logic                       load_o,       // load beat counter
  output logic                       clear_o,      // clear lane accumulators
  output logic                       beat_o,       // accepted beat
  output logic                       busy_o,       // block in progress
  output logic                       done_o,       // result ready pulse
  output smac_data_pkg::precision_e  prec_o        // latched precision
);

  smac_ctrl_pkg::ctrl_state_e state_q;
  smac_ctrl_pkg::ctrl_state_e state_d;
  smac_data_pkg::precision_e  prec_q;
  logic                       start_ok;    // start taken this cycle
  logic                       enter_done;  // moving into ST_DONE
  logic                       done_q;

  //////////////////////////////////////////////////
  // start and beat qualification
  //////////////////////////////////////////////////
  // start only counts when no block is running
  assign start_ok = start_i &&
                    ((state_q == smac_ctrl_pkg::ST_IDLE) ||
                     (state_q == smac_ctrl_pkg::ST_DONE));
  assign beat_o  = valid_i && (state_q == smac_ctrl_pkg::ST_RUN);  // strays dropped
  assign load_o  = start_ok;
  assign clear_o = start_ok;  // empty blocks are cleared too

  //////////////////////////////////////////////////
  // next state
  //////////////////////////////////////////////////
  always_comb begin
    state_d = state_q;
    case (state_q)
      smac_ctrl_pkg::ST_IDLE,
      smac_ctrl_pkg::ST_DONE: begin
        if (start_ok) begin
          state_d = len_zero_i ? smac_ctrl_pkg::ST_DONE : smac_ctrl_pkg::ST_RUN;
        end
      end
      smac_ctrl_pkg::ST_RUN: begin
        if (beat_o && last_i) state_d = smac_ctrl_pkg::ST_DRAIN;
      end
      smac_ctrl_pkg::ST_DRAIN: begin
        if (drained_i) state_d = smac_ctrl_pkg::ST_DONE;
      end
      default: state_d = smac_ctrl_pkg::ST_IDLE;
    endcase
  end

  // a zero-length start from ST_DONE re-enters and pulses again
  assign enter_done = (state_d == smac_ctrl_pkg::ST_DONE) &&
                      ((state_q != smac_ctrl_pkg::ST_DONE) || start_ok);

  //////////////////////////////////////////////////
  // registers
  //////////////////////////////////////////////////
  always_ff @(posedge clk) begin
    if (rst_i) begin
      state_q <= smac_ctrl_pkg::ST_IDLE;
      prec_q  <= smac_data_pkg::PREC_INT8;
      done_q  <= 1'b0;
    end else begin
      state_q <= state_d;
      done_q  <= enter_done;  // one cycle wide
      if (start_ok) prec_q <= precision_i;  // held until next start
    end
  end

  assign state_o = state_q;
  assign prec_o  = prec_q;
  assign done_o  = done_q;
  assign busy_o  = (state_q == smac_ctrl_pkg::ST_RUN) ||
                   (state_q == smac_ctrl_pkg::ST_DRAIN);  // falls with done

endmodule

// ==== logic/smac_top.sv ====
// packed mac top level
`timescale 1ns/1ps
`include "smac_config.svh"

module smac_top (
  input  logic                      clk,
  input  logic                      rst_i,
  input  logic                      start_i,      // start pulse
  input  smac_data_pkg::precision_e precision_i,  // lane precision
  input  logic [`SMAC_LEN_W-1:0]    len_i,        // beats in the block
  input  logic                      valid_i,      // beat strobe
  input  logic [`SMAC_DATA_W-1:0]   data_i,
  input  logic [`SMAC_DATA_W-1:0]   weight_i,
  output logic                      busy_o,
  output logic                      done_o,
  output logic [`SMAC_DATA_W-1:0]   result_o
);

  smac_ctrl_pkg::ctrl_state_e state;
  smac_data_pkg::precision_e  prec;     // precision of the running block
  logic                       len_zero;
  logic                       load;
  logic                       clear;
  logic                       beat;
  logic                       last;
  logic                       drained;

  assign len_zero = (len_i == '0);  // empty block goes straight to done

  //////////////////////////////////////////////////
  // control
  //////////////////////////////////////////////////
  mac_ctrl u_ctrl (
    .clk         (clk),
    .rst_i       (rst_i),
    .start_i     (start_i),
    .valid_i     (valid_i),
    .last_i      (last),
    .drained_i   (drained),
    .precision_i (precision_i),
    .len_zero_i  (len_zero),
    .state_o     (state),
    .load_o      (load),
    .clear_o     (clear),
    .beat_o      (beat),
    .busy_o      (busy_o),
    .done_o      (done_o),
    .prec_o      (prec)
  );

  beat_counter u_cnt (
    .clk       (clk),
    .rst_i     (rst_i),
    .load_i    (load),
    .beat_i    (beat),
    .len_i     (len_i),
    .state_i   (state),
    .last_o    (last),
    .drained_o (drained)
  );

  //////////////////////////////////////////////////
  // datapath
  //////////////////////////////////////////////////
  packed_mac u_mac (
    .clk         (clk),
    .rst_i       (rst_i),
    .clear_i     (clear),
    .beat_i      (beat),
    .precision_i (prec),
    .data_i      (data_i),
    .weight_i    (weight_i),
    .result_o    (result_o)
  );

endmodule

// ==== test/smac_assertions.sv ====
// packed mac assertion checker
`timescale 1ns/1ps
`include "smac_config.svh"

module smac_assertions (
  input logic                       clk,
  input logic                       rst_i,
  input logic                       start_i,
  input smac_data_pkg::precision_e  precision_i,
  input logic [`SMAC_LEN_W-1:0]     len_i,
  input logic                       valid_i,
  input logic [`SMAC_DATA_W-1:0]    data_i,
  input logic [`SMAC_DATA_W-1:0]    weight_i,
  input logic                       busy_i,    // dut busy_o
  input logic                       done_i,    // dut done_o
  input logic [`SMAC_DATA_W-1:0]    result_i,  // dut result_o
  input smac_ctrl_pkg::ctrl_state_e state_i    // sequencer state
);

  localparam int DW       = `SMAC_DATA_W;
  localparam int LW       = `SMAC_LEN_W;
  // done_o rises on edge DRAIN+1 after the last beat, sampled one tick later
  localparam int DONE_DLY = `SMAC_DRAIN + 2;
  localparam int W8       = $bits(smac_data_pkg::byte_t);
  localparam int W16      = $bits(smac_data_pkg::half_t);
  localparam int W32      = $bits(smac_data_pkg::word_t);

  logic                      start_acc;   // start seen while not busy
  logic                      zero_start;  // accepted start of an empty block
  logic                      beat_m;      // accepted beat, port view
  logic                      last_m;      // final beat of the block
  logic                      run_m;       // model is taking beats
  logic [LW-1:0]             rem_m;       // beats still expected
  smac_data_pkg::precision_e prec_m;
  logic [DW-1:0]             exp_m;       // expected packed sums
  int f_timing = 0;
  int f_cause  = 0;
  int f_pulse  = 0;
  int f_result = 0;
  int f_hold   = 0;
  int f_reset  = 0;
  int fail_cnt;                           // read by the testbench

  assign fail_cnt = f_timing + f_cause + f_pulse + f_result + f_hold + f_reset;

  // one packed step, every lane wraps at its own width
  function automatic logic [DW-1:0] mac_step(input logic [DW-1:0]             acc,
                                             input smac_data_pkg::precision_e prec,
                                             input logic [DW-1:0]             a,
                                             input logic [DW-1:0]             b);
    logic [DW-1:0]        sum;
    smac_data_pkg::byte_t p8;
    smac_data_pkg::half_t p16;
    smac_data_pkg::word_t p32;
    sum = acc;
    case (prec)
      smac_data_pkg::PREC_INT8: begin
        for (int i = 0; i < DW / W8; i++) begin
          p8 = a[i*W8 +: W8] * b[i*W8 +: W8];  // low byte of product
          sum[i*W8 +: W8] = sum[i*W8 +: W8] + p8;
        end
      end
      smac_data_pkg::PREC_INT16: begin
        for (int i = 0; i < DW / W16; i++) begin
          p16 = a[i*W16 +: W16] * b[i*W16 +: W16];
          sum[i*W16 +: W16] = sum[i*W16 +: W16] + p16;
        end
      end
      smac_data_pkg::PREC_INT32: begin
        for (int i = 0; i < DW / W32; i++) begin
          p32 = a[i*W32 +: W32] * b[i*W32 +: W32];
          sum[i*W32 +: W32] = sum[i*W32 +: W32] + p32;
        end
      end
      default: sum = acc;
    endcase
    return sum;
  endfunction

  //////////////////////////////////////////////////
  // reference model
  //////////////////////////////////////////////////
  assign start_acc  = start_i && !busy_i;
  assign zero_start = start_acc && (len_i == '0);
  assign beat_m     = valid_i && run_m;  // strays outside the run are dropped
  assign last_m     = beat_m && (rem_m == LW'(1));

  always_ff @(posedge clk) begin
    if (rst_i) begin
      run_m  <= 1'b0;
      rem_m  <= '0;
      prec_m <= smac_data_pkg::PREC_INT8;
      exp_m  <= '0;
    end else if (start_acc) begin
      run_m  <= (len_i != '0);
      rem_m  <= len_i;
      prec_m <= precision_i;
      exp_m  <= '0;  // new block starts from zero
    end else if (beat_m) begin
      rem_m <= rem_m - LW'(1);
      exp_m <= mac_step(exp_m, prec_m, data_i, weight_i);
      if (last_m) run_m <= 1'b0;
    end
  end

  //////////////////////////////////////////////////
  // checks
  //////////////////////////////////////////////////
  a_done_timing: assert property (@(posedge clk) disable iff (rst_i)
    $past(last_m, DONE_DLY) |-> (done_i && !busy_i && $past(busy_i)))
    else begin
      $error("done_o did not rise with busy_o falling 3 cycles after the last beat");
      f_timing++;
    end

  a_done_cause: assert property (@(posedge clk) disable iff (rst_i)
    done_i |-> ($past(last_m, DONE_DLY) || $past(zero_start)))
    else begin
      $error("done_o rose without a finished block");
      f_cause++;
    end

  a_done_pulse: assert property (@(posedge clk) disable iff (rst_i)
    (done_i && !zero_start) |=> !done_i)
    else begin
      $error("done_o stayed high for more than one cycle");
      f_pulse++;
    end

  a_result: assert property (@(posedge clk) disable iff (rst_i)
    done_i |-> (result_i == exp_m))
    else begin
      $error("result_o = 0x%016h at done, expected 0x%016h", result_i, exp_m);
      f_result++;
    end

  a_hold: assert property (@(posedge clk) disable iff (rst_i)
    (!busy_i && !start_acc) |=> (result_i == $past(result_i)))
    else begin
      $error("result_o changed while no block was running");
      f_hold++;
    end

  a_reset: assert property (@(posedge clk)
    rst_i |=> (!busy_i && !done_i && (result_i == '0) &&
               (state_i == smac_ctrl_pkg::ST_IDLE)))
    else begin
      $error("outputs not at their reset values after reset");
      f_reset++;
    end

endmodule

bind smac_top smac_assertions u_chk (
  .clk         (clk),
  .rst_i       (rst_i),
  .start_i     (start_i),
  .precision_i (precision_i),
  .len_i       (len_i),
  .valid_i     (valid_i),
  .data_i      (data_i),
  .weight_i    (weight_i),
  .busy_i      (busy_o),
  .done_i      (done_o),
  .result_i    (result_o),
  .state_i     (state)
);

// ==== test/smac_tb.sv ====
// packed mac testbench
`timescale 1ns/1ps
`include "smac_config.svh"

module smac_tb;

  localparam int DW         = `SMAC_DATA_W;
  localparam int LW         = `SMAC_LEN_W;
  localparam int CLK_PERIOD = 100;
  localparam int RST_CYC    = 5;
  localparam int MAX_LEN    = 40;  // bound of random block lengths
  localparam int MAX_GAP    = 3;   // idle cycles between beats, gap test
  localparam int GAP_LEN    = 12;  // beats in the gap test
  localparam int DONE_WAIT  = `SMAC_DRAIN + 4;
  localparam int N_TESTS    = 7;
  // cycles of all tests in run order, gaps counted at their longest
  localparam int RUN_CYC = (RST_CYC + 3) + 16 + MAX_LEN + MAX_LEN +
                           (GAP_LEN * (MAX_GAP + 1) + 8) + (8 + 6) + (12 + 6);
  localparam int WATCHDOG_CYC = RUN_CYC + 10 * N_TESTS;

  logic                      clk;
  logic                      rst_i;
  logic                      start_i;
  smac_data_pkg::precision_e precision_i;
  logic [LW-1:0]             len_i;
  logic                      valid_i;
  logic [DW-1:0]             data_i;
  logic [DW-1:0]             weight_i;
  logic                      busy_o;
  logic                      done_o;
  logic [DW-1:0]             result_o;

  logic [31:0] lcg_q;       // generator state
  int          n_pass;
  int          n_fail;
  int          base_fails;  // checker count at test start
  int          blk_len;
  logic        seen;        // done_o observed

  always #(CLK_PERIOD / 2) clk = ~clk;

  smac_top dut_i (
    .clk         (clk),
    .rst_i       (rst_i),
    .start_i     (start_i),
    .precision_i (precision_i),
    .len_i       (len_i),
    .valid_i     (valid_i),
    .data_i      (data_i),
    .weight_i    (weight_i),
    .busy_o      (busy_o),
    .done_o      (done_o),
    .result_o    (result_o)
  );

  //////////////////////////////////////////////////
  // stimulus helpers, all entered just after a falling edge
  //////////////////////////////////////////////////
  function automatic logic [31:0] next_random();
    lcg_q = lcg_q * 32'd1664525 + 32'd1013904223;
    return lcg_q;
  endfunction

  function automatic int rand_below(input int n);
    return int'(next_random() >> 8) % n;  // upper bits mix better
  endfunction

  task automatic idle(input int n);
    repeat (n) @(negedge clk);
  endtask

  task automatic drive_operands();
    data_i   = {next_random(), next_random()};
    weight_i = {next_random(), next_random()};
  endtask

  task automatic start_block(input smac_data_pkg::precision_e prec, input int len);
    start_i     = 1'b1;
    precision_i = prec;
    len_i       = LW'(len);
    @(negedge clk);
    start_i = 1'b0;
  endtask

  task automatic send_beats(input int n, input int max_gap);
    int gap;
    repeat (n) begin
      gap = rand_below(max_gap + 1);
      idle(gap);
      drive_operands();
      valid_i = 1'b1;
      @(negedge clk);
      valid_i = 1'b0;
    end
  endtask

  task automatic stray_pulses(input int n);
    repeat (n) begin
      drive_operands();
      valid_i = 1'b1;  // nobody should take these
      @(negedge clk);
    end
    valid_i = 1'b0;
  endtask

  // waits for done_o, optionally strobing valid_i during the drain
  task automatic wait_done(input logic strays, output logic got);
    int n;
    n = 0;
    while (!done_o && n < DONE_WAIT) begin
      if (strays) begin
        drive_operands();
        valid_i = 1'b1;
      end
      @(negedge clk);
      n++;
    end
    valid_i = 1'b0;
    got     = done_o;
  endtask

  task automatic begin_test();
    base_fails = dut_i.u_chk.fail_cnt;
  endtask

  task automatic end_test(input string name, input logic got);
    int now_fails;
    now_fails = dut_i.u_chk.fail_cnt;
    if (!got) begin
      $display("test %s: done_o never rose", name);
      n_fail++;
    end else if (now_fails != base_fails) begin
      $display("** Error test %s: u_chk.fail_cnt = 0x%08h, expected 0x%08h",
               name, now_fails, base_fails);
      n_fail++;
    end else begin
      $display("test %s: ok", name);
      n_pass++;
    end
  endtask

  //////////////////////////////////////////////////
  // test sequence
  //////////////////////////////////////////////////
  initial begin : main
    clk         = 1'b0;
    rst_i       = 1'b1;
    start_i     = 1'b0;
    precision_i = smac_data_pkg::PREC_INT8;
    len_i       = '0;
    valid_i     = 1'b0;
    data_i      = '0;
    weight_i    = '0;
    lcg_q       = 32'h462d8731;
    n_pass      = 0;
    n_fail      = 0;

    begin_test();
    idle(RST_CYC);
    rst_i = 1'b0;
    idle(3);  // reset values checked here
    end_test("reset", 1'b1);

    begin_test();
    start_block(smac_data_pkg::PREC_INT8, 16);
    send_beats(16, 0);  // back to back
    wait_done(1'b0, seen);
    idle(2);
    end_test("int8_block", seen);

    begin_test();
    blk_len = 1 + rand_below(MAX_LEN);
    start_block(smac_data_pkg::PREC_INT16, blk_len);
    send_beats(blk_len, 0);
    wait_done(1'b0, seen);
    idle(2);
    end_test("int16_block", seen);

    begin_test();
    blk_len = 1 + rand_below(MAX_LEN);
    start_block(smac_data_pkg::PREC_INT32, blk_len);
    send_beats(blk_len, 0);
    wait_done(1'b0, seen);
    idle(2);
    end_test("int32_block", seen);

    begin_test();
    stray_pulses(3);  // before start
    start_block(smac_data_pkg::PREC_INT16, GAP_LEN);
    send_beats(GAP_LEN, MAX_GAP);
    wait_done(1'b1, seen);  // strobes during the drain
    stray_pulses(2);        // and after done
    idle(1);
    end_test("gaps_and_strays", seen);

    begin_test();
    start_block(smac_data_pkg::PREC_INT32, 8);
    send_beats(8, 0);
    wait_done(1'b0, seen);
    idle(6);  // result must hold
    end_test("done_timing_hold", seen);

    begin_test();
    start_block(smac_data_pkg::PREC_INT8, 12);
    send_beats(4, 0);
    start_block(smac_data_pkg::PREC_INT32, 0);  // busy, must be ignored
    send_beats(8, 0);
    wait_done(1'b0, seen);
    if (seen) begin
      start_block(smac_data_pkg::PREC_INT16, 0);  // empty block
      wait_done(1'b0, seen);
    end
    idle(2);
    end_test("ignored_start_empty", seen);

    $display("tests passed %0d failed %0d", n_pass, n_fail);
    if (n_fail == 0 && dut_i.u_chk.fail_cnt == 0) begin
      $display("ALL TESTS PASSED");
    end else begin
      $display("SOME TESTS FAILED");
    end
    $finish;
  end

  initial begin : watchdog
    #(WATCHDOG_CYC * CLK_PERIOD);
    $display("timeout: run did not finish within %0d cycles", WATCHDOG_CYC);
    $display("SOME TESTS FAILED");
    $finish;
  end

endmodule

// ==== src.f ====
+incdir+logic
logic/smac_data_pkg.sv
logic/smac_ctrl_pkg.sv
logic/mac_lane.sv
logic/packed_mac.sv
logic/beat_counter.sv
logic/mac_ctrl.sv
logic/smac_top.sv
test/smac_assertions.sv
test/smac_tb.sv

// ==== run.sh ====
#!/bin/sh
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert --timescale 1ns/1ps --top-module smac_tb \
  -f src.f -o smac_sim > build.log 2>&1 || { cat build.log; exit 1; }
./obj_dir/smac_sim +verilator+error+limit+1000 > sim.log 2>&1 ||
  { cat sim.log; exit 1; }
cat sim.log
grep -q "SOME TESTS FAILED" sim.log && exit 1 || exit 0
